// File: logic/systolic_pkg.sv
package systolic_pkg;

  localparam int array_n = 4;  // Array side, FIFO depth and lane count
  localparam int data_w  = 16;
  localparam int frac_w  = 8;  // Q8.8 fixed point
  localparam int sel_w   = $clog2(array_n);
  localparam int cnt_w   = $clog2(3 * array_n + 3);

  typedef logic signed [data_w-1:0] data_t;

  typedef logic [sel_w-1:0] sel_t;

  typedef data_t [array_n-1:0] lane_vec_t;

  typedef logic [array_n-1:0] lane_bits_t;

  // One load strobe carries column k of X and row k of W
  typedef struct packed {
    lane_vec_t x_col;  // Element per row
    lane_vec_t w_row;  // Element per column
  } load_word_t;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain
  } ctrl_state_t;

endpackage

// File: logic/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo (
  input  logic                clk,
  input  logic                reset,
  input  logic                wr_en,
  input  logic                rd_en,
  input  systolic_pkg::data_t wr_data,
  output systolic_pkg::data_t rd_data,
  output logic                full,
  output logic                empty
);

  import systolic_pkg::*;

  data_t          mem [array_n];
  sel_t           wr_ptr;
  sel_t           rd_ptr;
  logic [sel_w:0] count;
  logic           do_wr;
  logic           do_rd;

  assign full  = (count == (sel_w + 1)'(array_n));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      rd_data <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, pointers wrap
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      rd_data <= do_rd ? mem[rd_ptr] : '0;  // Zero padding outside the read window
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_read_empty: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
    else $error("sync_fifo read while empty");

  a_count_bound: assert property (@(posedge clk) disable iff (reset) count <= array_n)
    else $error("sync_fifo count above depth");

endmodule

// File: logic/systolic_pe.sv
`timescale 1ns/10ps

module systolic_pe (
  input  logic                clk,
  input  logic                reset,
  input  logic                clear,
  input  logic                mac_en,
  input  systolic_pkg::data_t x_in,
  input  systolic_pkg::data_t w_in,
  output systolic_pkg::data_t x_out,
  output systolic_pkg::data_t w_out,
  output systolic_pkg::data_t acc
);

  import systolic_pkg::*;

  logic signed [2*data_w-1:0] prod;
  logic signed [2*data_w-1:0] prod_shift;
  data_t                      prod_trunc;

  assign prod       = x_in * w_in;         // Full signed product
  assign prod_shift = prod >>> frac_w;     // Back to Q8.8, low bits dropped
  assign prod_trunc = prod_shift[data_w-1:0];

  // Operand hops to the right and downward
  always_ff @(posedge clk) begin
    x_out <= x_in;
    w_out <= w_in;
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else if (mac_en) begin
      acc <= acc + prod_trunc;  // Wraps on overflow
    end
  end

endmodule

// File: logic/systolic_dpath.sv
`timescale 1ns/10ps

module systolic_dpath (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  systolic_pkg::load_word_t load_word,
  input  systolic_pkg::lane_bits_t rd_en,
  input  logic                     clear,
  input  logic                     mac_en,
  input  systolic_pkg::sel_t       row_sel,
  input  systolic_pkg::sel_t       col_sel,
  output systolic_pkg::data_t      result,
  output systolic_pkg::lane_bits_t fifo_full,
  output systolic_pkg::lane_bits_t fifo_empty
);

  import systolic_pkg::*;

  data_t      x_hop [array_n][array_n+1];  // Row i, column j input
  data_t      w_hop [array_n+1][array_n];  // Row i input, column j
  data_t      acc   [array_n][array_n];
  lane_bits_t x_full;
  lane_bits_t x_empty;
  lane_bits_t w_full;
  lane_bits_t w_empty;
  logic       load_ok;

  // All lanes write together, so a load is dropped unless every lane has room
  assign load_ok = load && !(|fifo_full);

  for (genvar i = 0; i < array_n; i++) begin : g_lane
    sync_fifo i_x_fifo (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (load_ok),
      .rd_en   (rd_en[i]),
      .wr_data (load_word.x_col[i]),
      .rd_data (x_hop[i][0]),
      .full    (x_full[i]),
      .empty   (x_empty[i])
    );

    sync_fifo i_w_fifo (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (load_ok),
      .rd_en   (rd_en[i]),
      .wr_data (load_word.w_row[i]),
      .rd_data (w_hop[0][i]),
      .full    (w_full[i]),
      .empty   (w_empty[i])
    );
  end

  assign fifo_full  = x_full | w_full;
  assign fifo_empty = x_empty & w_empty;

  for (genvar i = 0; i < array_n; i++) begin : g_row
    for (genvar j = 0; j < array_n; j++) begin : g_col
      systolic_pe i_pe (
        .clk    (clk),
        .reset  (reset),
        .clear  (clear),
        .mac_en (mac_en),
        .x_in   (x_hop[i][j]),
        .w_in   (w_hop[i][j]),
        .x_out  (x_hop[i][j+1]),
        .w_out  (w_hop[i+1][j]),
        .acc    (acc[i][j])
      );
    end
  end

  assign result = acc[row_sel][col_sel];

endmodule

// File: logic/systolic_ctrl.sv
`timescale 1ns/10ps

module systolic_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  systolic_pkg::lane_bits_t fifo_full,
  output logic                     clear,
  output logic                     mac_en,
  output systolic_pkg::lane_bits_t rd_en,
  output logic                     busy,
  output logic                     done
);

  import systolic_pkg::*;

  ctrl_state_t      state;
  logic [cnt_w-1:0] cnt;
  logic             start_ok;
  logic             run_last;
  logic             drain_last;

  assign start_ok   = start && (state == st_idle) && (&fifo_full);
  assign run_last   = (cnt == cnt_w'(2 * array_n - 1));  // Last read of lane N-1
  assign drain_last = (cnt == cnt_w'(3 * array_n + 1));  // Product has reached PE(N-1,N-1)

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          cnt <= '0;
          if (start_ok) state <= st_run;
        end
        st_run: begin
          cnt <= cnt + 1'b1;
          if (run_last) state <= st_drain;
        end
        st_drain: begin
          if (drain_last) begin
            state <= st_idle;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Lane i reads during cycles i+1 .. i+array_n
  always_comb begin
    rd_en = '0;
    for (int i = 0; i < array_n; i++) begin
      rd_en[i] = (state == st_run) && (cnt >= cnt_w'(i + 1)) &&
                 (cnt <= cnt_w'(i + array_n));
    end
  end

  assign clear  = (state == st_run) && (cnt == '0);
  assign mac_en = ((state == st_run) && (cnt != '0)) || (state == st_drain);
  assign busy   = (state != st_idle);
  assign done   = (state == st_drain) && drain_last;

  a_rd_clear: assert property (@(posedge clk) disable iff (reset) clear |-> (rd_en == '0))
    else $error("systolic_ctrl read during clear");

endmodule

// File: logic/systolic_top.sv
`timescale 1ns/10ps

module systolic_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  systolic_pkg::load_word_t load_word,
  input  logic                     start,
  input  systolic_pkg::sel_t       row_sel,
  input  systolic_pkg::sel_t       col_sel,
  output systolic_pkg::data_t      result,
  output logic                     busy,
  output logic                     done,
  output logic                     load_full,
  output logic                     load_empty
);

  import systolic_pkg::*;

  lane_bits_t fifo_full;
  lane_bits_t fifo_empty;
  lane_bits_t rd_en;
  logic       clear;
  logic       mac_en;

  systolic_ctrl i_systolic_ctrl (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .fifo_full (fifo_full),
    .clear     (clear),
    .mac_en    (mac_en),
    .rd_en     (rd_en),
    .busy      (busy),
    .done      (done)
  );

  systolic_dpath i_systolic_dpath (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .load_word  (load_word),
    .rd_en      (rd_en),
    .clear      (clear),
    .mac_en     (mac_en),
    .row_sel    (row_sel),
    .col_sel    (col_sel),
    .result     (result),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  assign load_full  = |fifo_full;
  assign load_empty = &fifo_empty;

endmodule

// File: test/systolic_checker.sv
`timescale 1ns/10ps

module systolic_checker (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  systolic_pkg::load_word_t load_word,
  input  logic                     start,
  input  systolic_pkg::sel_t       row_sel,
  input  systolic_pkg::sel_t       col_sel,
  input  systolic_pkg::data_t      result,
  input  logic                     busy,
  input  logic                     done,
  input  logic                     load_full,
  input  logic                     load_empty,
  input  logic                     check_en,
  input  logic                     test_end,
  input  logic [95:0]              test_name,
  output int                       errors,
  output int                       passed,
  output int                       failed
);

  import systolic_pkg::*;

  load_word_t words [$];  // Model of the lane FIFO contents
  load_word_t op [array_n];
  data_t      exp_c [array_n][array_n];
  logic       running;
  int         cyc;
  int         base;  // Error count when the current test began

  // Q8.8 product with the low fraction bits dropped and wrapped to data_w
  function automatic data_t fx_mul(data_t a, data_t b);
    logic signed [2*data_w-1:0] p;
    p = a * b;
    return data_t'(p >>> frac_w);
  endfunction

  task automatic compare(string name, int exp_v, int got_v);
    if (exp_v != got_v) begin
      errors++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp_v, got_v);
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      words.delete();
      running = 1'b0;
      cyc     = 0;
      errors  = 0;
      passed  = 0;
      failed  = 0;
      base    = 0;
    end else begin
      compare("busy", running, busy);
      if (!running) begin
        compare("load_full", words.size() == array_n, load_full);
        compare("load_empty", words.size() == 0, load_empty);
        compare("done", 0, done);
      end else begin
        cyc++;
        compare("done", cyc == 3 * array_n + 2, done);  // Fixed latency after start
        if (done) running = 1'b0;
      end
      if (check_en) begin
        compare($sformatf("result[%0d][%0d]", row_sel, col_sel),
                exp_c[row_sel][col_sel], result);
      end
      if (load && words.size() < array_n) words.push_back(load_word);
      if (start && !running && words.size() == array_n) begin
        for (int k = 0; k < array_n; k++) op[k] = words.pop_front();
        for (int i = 0; i < array_n; i++) begin
          for (int j = 0; j < array_n; j++) begin
            exp_c[i][j] = '0;
            for (int k = 0; k < array_n; k++) begin
              exp_c[i][j] = exp_c[i][j] + fx_mul(op[k].x_col[i], op[k].w_row[j]);
            end
          end
        end
        running = 1'b1;
        cyc     = 0;
      end
      if (test_end) begin
        if (errors == base) begin
          passed++;
          $display("PASS test %0s", test_name);
        end else begin
          failed++;
          $display("FAIL test %0s with %0d errors", test_name, errors - base);
        end
        base = errors;
      end
    end
  end

endmodule

// File: test/systolic_tb.sv
`timescale 1ns/10ps

module systolic_tb;

  import systolic_pkg::*;

  localparam int n_tests = 6;
  localparam int limit   = n_tests * (array_n + 3 * array_n + 2 + array_n * array_n + 20);

  typedef enum int {k_flags, k_plain, k_bad_start, k_overlap} kind_t;

  logic        clk;
  logic        reset;
  logic        load;
  load_word_t  load_word;
  logic        start;
  sel_t        row_sel;
  sel_t        col_sel;
  data_t       result;
  logic        busy;
  logic        done;
  logic        load_full;
  logic        load_empty;
  logic        check_en;
  logic        test_end;
  logic [95:0] test_name;
  int          errors;
  int          passed;
  int          failed;
  int          cycles;

  logic [95:0] names [n_tests];
  kind_t       kinds [n_tests];
  data_t       xm [n_tests][array_n][array_n];
  data_t       wm [n_tests][array_n][array_n];

  systolic_top i_systolic_top (.*);

  systolic_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  function automatic data_t small_rand();
    data_t v;
    v = data_t'($urandom_range(1023));
    return v - 16'sd512;  // About -2.0 to +2.0
  endfunction

  task automatic fill_table();
    names = '{"flags", "identity", "random", "wide_wrap", "bad_start", "back_to_back"};
    kinds = '{k_flags, k_plain, k_plain, k_plain, k_bad_start, k_overlap};
    for (int t = 0; t < n_tests; t++) begin
      for (int i = 0; i < array_n; i++) begin
        for (int j = 0; j < array_n; j++) begin
          xm[t][i][j] = small_rand();
          wm[t][i][j] = small_rand();
          if (t == 1) xm[t][i][j] = (i == j) ? 16'sd256 : 16'sd0;  // 1.0 on the diagonal
          if (t == 3) begin
            xm[t][i][j] = data_t'($urandom);
            wm[t][i][j] = data_t'($urandom);
          end
        end
      end
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Strobe k carries column k of X and row k of W
  task automatic load_words(int t, int k0, int k1);
    for (int k = k0; k < k1; k++) begin
      for (int i = 0; i < array_n; i++) begin
        load_word.x_col[i] = xm[t][i][k];
        load_word.w_row[i] = wm[t][k][i];
      end
      load = 1'b1;
      step();
      load = 1'b0;
    end
  endtask

  task automatic pulse_start();
    start = 1'b1;
    step();
    start = 1'b0;
  endtask

  task automatic wait_done();
    @(posedge clk);
    while (!done) @(posedge clk);
    #1;
  endtask

  task automatic sweep_results();
    check_en = 1'b1;
    for (int r = 0; r < array_n; r++) begin
      for (int c = 0; c < array_n; c++) begin
        row_sel = sel_t'(r);
        col_sel = sel_t'(c);
        step();
      end
    end
    check_en = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h326b0b0a));
    cycles    = 0;
    reset     = 1'b1;
    load      = 1'b0;
    load_word = '0;
    start     = 1'b0;
    row_sel   = '0;
    col_sel   = '0;
    check_en  = 1'b0;
    test_end  = 1'b0;
    test_name = '0;
    fill_table();
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    for (int t = 0; t < n_tests; t++) begin
      test_name = names[t];
      case (kinds[t])
        k_flags: begin
          load_words(t, 0, array_n);
          load_words(t, 0, 1);  // FIFOs full, so this load is dropped
          pulse_start();
        end
        k_bad_start: begin
          pulse_start();  // Empty FIFOs
          load_words(t, 0, array_n - 1);
          pulse_start();  // One word short
          load_words(t, array_n - 1, array_n);
          pulse_start();
          pulse_start();  // Already busy
        end
        k_overlap: pulse_start();  // Loaded during the previous run
        default: begin
          load_words(t, 0, array_n);
          pulse_start();
        end
      endcase
      if (t + 1 < n_tests && kinds[t + 1] == k_overlap) begin
        while (load_full) step();
        load_words(t + 1, 0, array_n);
      end
      wait_done();
      sweep_results();
      test_end = 1'b1;
      step();
      test_end = 1'b0;
    end
    step();
    $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/systolic_pkg.sv
logic/sync_fifo.sv
logic/systolic_pe.sv
logic/systolic_dpath.sv
logic/systolic_ctrl.sv
logic/systolic_top.sv
test/systolic_checker.sv
test/systolic_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module systolic_tb -o systolic_sim
out=$(./obj_dir/systolic_sim)
echo "$out"
echo "$out" | grep -q "^sim passed$"
